/* include/periph_params.svh */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// device windows, 8 bytes each, matched on address bits 31:3
`define UART_BASE  32'ha00003f8
`define MTIME_BASE 32'ha0000048

// word select inside a window, taken from address bit 2
`define UART_DATA_OFS 1'b0
`define UART_STAT_OFS 1'b1
`define MTIME_LO_OFS  1'b0
`define MTIME_HI_OFS  1'b1

// serial bit period in clocks, kept short for simulation
`define UART_CLKS_PER_BIT 8

`endif

/* src/periph_pkg.sv */
`default_nettype none

package periph_pkg;

    // target of a decoded request
    typedef enum logic [1:0] {
        dev_none  = 2'd0,
        dev_uart  = 2'd1,
        dev_mtime = 2'd2
    } periph_dev_e;

    // AXI response codes, EXOKAY is never returned
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

/* src/axil_req_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module axil_req_decode (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [31:0]              awaddr,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire [31:0]              wdata,
    input  wire                     wvalid,
    output logic                    wready,
    input  wire [31:0]              araddr,
    input  wire                     arvalid,
    output logic                    arready,
    input  wire                     wr_retire,
    input  wire                     rd_retire,
    output logic                    wr_strobe,
    output periph_pkg::periph_dev_e wr_dev,
    output logic                    wr_offset,
    output logic [31:0]             wr_data,
    output logic                    rd_strobe,
    output periph_pkg::periph_dev_e rd_dev,
    output logic                    rd_offset
);
    import periph_pkg::*;

    localparam logic [31:0] uart_base  = `UART_BASE;
    localparam logic [31:0] mtime_base = `MTIME_BASE;

    logic        aw_hand;
    logic        w_hand;
    logic        ar_hand;
    logic [31:0] waddr;
    logic [31:0] raddr;

    function automatic periph_dev_e match_dev(input logic [31:0] addr);
        if (addr[31:3] == uart_base[31:3]) begin
            return dev_uart;
        end else if (addr[31:3] == mtime_base[31:3]) begin
            return dev_mtime;
        end
        return dev_none;
    endfunction

    // AW and W captured independently, each ready stays low until retire
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            aw_hand <= 1'b0;
            w_hand  <= 1'b0;
        end else begin
            if (awready && awvalid) begin
                awready <= 1'b0;
                aw_hand <= 1'b1;
            end else if (wr_strobe) begin
                aw_hand <= 1'b0;
            end
            if (wready && wvalid) begin
                wready <= 1'b0;
                w_hand <= 1'b1;
            end else if (wr_strobe) begin
                w_hand <= 1'b0;
            end
            if (wr_retire) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
        end
    end

    // read address, strobe lasts the single cycle after the handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            ar_hand <= 1'b0;
        end else begin
            if (arready && arvalid) begin
                arready <= 1'b0;
                ar_hand <= 1'b1;
            end else begin
                ar_hand <= 1'b0;
            end
            if (rd_retire) begin
                arready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awready && awvalid) begin
            waddr <= awaddr;
        end
        if (wready && wvalid) begin
            wr_data <= wdata;
        end
        if (arready && arvalid) begin
            raddr <= araddr;
        end
    end

    // both halves in hand, fire once
    assign wr_strobe = aw_hand && w_hand;
    assign wr_dev    = match_dev(waddr);
    assign wr_offset = waddr[2];

    assign rd_strobe = ar_hand;
    assign rd_dev    = match_dev(raddr);
    assign rd_offset = raddr[2];

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module uart_tx (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_strobe,
    input  wire periph_pkg::periph_dev_e wr_dev,
    input  wire                     wr_offset,
    input  wire [31:0]              wr_data,
    input  wire                     rd_offset,
    output logic [31:0]             rd_data,
    output logic                    uart_reject,
    output logic                    uart_txd
);
    import periph_pkg::*;

    localparam int clks_per_bit = `UART_CLKS_PER_BIT;
    localparam int cnt_w        = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] last_clk = cnt_w'(clks_per_bit - 1);

    logic             data_wr;
    logic             busy;
    logic [9:0]       frame;
    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;

    // write to the data register
    assign data_wr     = wr_strobe && (wr_dev == dev_uart) && (wr_offset == `UART_DATA_OFS);
    assign uart_reject = data_wr && busy;

    // frame is stop, data LSB first, start; ones shift in behind it
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (data_wr) begin
                busy     <= 1'b1;
                frame    <= {1'b1, wr_data[7:0], 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == last_clk) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                // stop bit done
                busy    <= 1'b0;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // idle line is high since the frame refills with ones
    assign uart_txd = frame[0];

    // status word holds busy in bit 0, the data register reads as zero
    always_comb begin
        rd_data = 32'h0;
        if (rd_offset == `UART_STAT_OFS) begin
            rd_data[0] = busy;
        end
    end

endmodule

`default_nettype wire

/* src/mtime_counter.sv */
`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module mtime_counter (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_strobe,
    input  wire periph_pkg::periph_dev_e wr_dev,
    input  wire                     wr_offset,
    input  wire [31:0]              wr_data,
    input  wire                     rd_offset,
    output logic [31:0]             rd_data
);
    import periph_pkg::*;

    logic        wr_hit;
    logic [63:0] mtime;
    logic [63:0] mtime_inc;

    assign wr_hit    = wr_strobe && (wr_dev == dev_mtime);
    assign mtime_inc = mtime + 64'd1;

    // loaded half replaces the count, the other half still takes the carry
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= 64'h0;
        end else if (wr_hit && (wr_offset == `MTIME_LO_OFS)) begin
            mtime <= {mtime_inc[63:32], wr_data};
        end else if (wr_hit) begin
            mtime <= {wr_data, mtime_inc[31:0]};
        end else begin
            mtime <= mtime_inc;
        end
    end

    assign rd_data = (rd_offset == `MTIME_HI_OFS) ? mtime[63:32] : mtime[31:0];

endmodule

`default_nettype wire

/* src/axil_resp.sv */
`default_nettype none
`timescale 1ns/1ps

module axil_resp (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_strobe,
    input  wire periph_pkg::periph_dev_e wr_dev,
    input  wire                     uart_reject,
    input  wire                     bready,
    input  wire                     rd_strobe,
    input  wire periph_pkg::periph_dev_e rd_dev,
    input  wire [31:0]              uart_rd_data,
    input  wire [31:0]              mtime_rd_data,
    input  wire                     rready,
    output periph_pkg::axi_resp_e   bresp,
    output logic                    bvalid,
    output logic [31:0]             rdata,
    output periph_pkg::axi_resp_e   rresp,
    output logic                    rvalid,
    output logic                    wr_retire,
    output logic                    rd_retire
);
    import periph_pkg::*;

    // handshakes release the decode side
    assign wr_retire = bvalid && bready;
    assign rd_retire = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_strobe) begin
                bvalid <= 1'b1;
            end else if (wr_retire) begin
                bvalid <= 1'b0;
            end
            if (rd_strobe) begin
                rvalid <= 1'b1;
            end else if (rd_retire) begin
                rvalid <= 1'b0;
            end
        end
    end

    // DECERR first, then SLVERR for a busy UART
    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            if (wr_dev == dev_none) begin
                bresp <= resp_decerr;
            end else if (uart_reject) begin
                bresp <= resp_slverr;
            end else begin
                bresp <= resp_okay;
            end
        end
    end

    // read word held with rvalid until rready
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            case (rd_dev)
                dev_uart: begin
                    rdata <= uart_rd_data;
                    rresp <= resp_okay;
                end
                dev_mtime: begin
                    rdata <= mtime_rd_data;
                    rresp <= resp_okay;
                end
                default: begin
                    rdata <= 32'h0;
                    rresp <= resp_decerr;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/periph_top.sv */
`default_nettype none
`timescale 1ns/1ps

module periph_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [31:0]            awaddr,
    input  wire                   awvalid,
    output wire                   awready,
    input  wire [31:0]            wdata,
    input  wire                   wvalid,
    output wire                   wready,
    output periph_pkg::axi_resp_e bresp,
    output wire                   bvalid,
    input  wire                   bready,
    input  wire [31:0]            araddr,
    input  wire                   arvalid,
    output wire                   arready,
    output wire [31:0]            rdata,
    output periph_pkg::axi_resp_e rresp,
    output wire                   rvalid,
    input  wire                   rready,
    output wire                   uart_txd
);
    import periph_pkg::*;

    // decode to devices and response block
    wire              wr_strobe;
    wire periph_dev_e wr_dev;
    wire              wr_offset;
    wire [31:0]       wr_data;
    wire              rd_strobe;
    wire periph_dev_e rd_dev;
    wire              rd_offset;

    // device read words and retire strobes
    wire [31:0] uart_rd_data;
    wire [31:0] mtime_rd_data;
    wire        uart_reject;
    wire        wr_retire;
    wire        rd_retire;

    axil_req_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .wr_retire (wr_retire),
        .rd_retire (rd_retire),
        .wr_strobe (wr_strobe),
        .wr_dev    (wr_dev),
        .wr_offset (wr_offset),
        .wr_data   (wr_data),
        .rd_strobe (rd_strobe),
        .rd_dev    (rd_dev),
        .rd_offset (rd_offset)
    );

    uart_tx u_uart (
        .clk         (clk),
        .rst         (rst),
        .wr_strobe   (wr_strobe),
        .wr_dev      (wr_dev),
        .wr_offset   (wr_offset),
        .wr_data     (wr_data),
        .rd_offset   (rd_offset),
        .rd_data     (uart_rd_data),
        .uart_reject (uart_reject),
        .uart_txd    (uart_txd)
    );

    mtime_counter u_mtime (
        .clk       (clk),
        .rst       (rst),
        .wr_strobe (wr_strobe),
        .wr_dev    (wr_dev),
        .wr_offset (wr_offset),
        .wr_data   (wr_data),
        .rd_offset (rd_offset),
        .rd_data   (mtime_rd_data)
    );

    axil_resp u_resp (
        .clk           (clk),
        .rst           (rst),
        .wr_strobe     (wr_strobe),
        .wr_dev        (wr_dev),
        .uart_reject   (uart_reject),
        .bready        (bready),
        .rd_strobe     (rd_strobe),
        .rd_dev        (rd_dev),
        .uart_rd_data  (uart_rd_data),
        .mtime_rd_data (mtime_rd_data),
        .rready        (rready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .wr_retire     (wr_retire),
        .rd_retire     (rd_retire)
    );

endmodule

`default_nettype wire

/* verif/periph_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_tb;

    // AXI response codes as the bus defines them
    localparam logic [1:0] okay   = 2'b00;
    localparam logic [1:0] slverr = 2'b10;
    localparam logic [1:0] decerr = 2'b11;
    localparam int limit = 200;

    logic        clk;
    logic        rst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
    wire         awready;
    wire         wready;
    wire  [1:0]  bresp;
    wire         bvalid;
    wire         arready;
    wire  [31:0] rdata;
    wire  [1:0]  rresp;
    wire         rvalid;
    wire         uart_txd;

    integer seed;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     test_errs = 0;
    int     cycle_cnt = 0;

    periph_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .uart_txd (uart_txd)
    );

    always #2 clk = ~clk;

    // free cycle count for latency measurements
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s: got %0h, expected %0h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        fail_cnt++;
    endtask

    task automatic report_test(input string name);
        if (fail_cnt == test_errs) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, fail_cnt - test_errs);
        end
        test_errs = fail_cnt;
    endtask

    // valids start after their own delay, hs_at is the later handshake
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input int aw_delay, input int w_delay,
                             output logic [1:0] resp, output int hs_at, output int b_lat);
        int n;
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        hs_at   = cycle_cnt;
        n       = 0;
        while (!(aw_done && w_done) && n < limit) begin
            if (!aw_done && n >= aw_delay) begin
                awaddr  = addr;
                awvalid = 1'b1;
            end
            if (!w_done && n >= w_delay) begin
                wdata  = data;
                wvalid = 1'b1;
            end
            // handshake lands on the coming rising edge
            if (!aw_done && awvalid && awready) begin
                aw_done = 1'b1;
                hs_at   = cycle_cnt;
            end
            if (!w_done && wvalid && wready) begin
                w_done = 1'b1;
                hs_at  = cycle_cnt;
            end
            @(negedge clk);
            n++;
            if (aw_done) begin
                awvalid = 1'b0;
            end
            if (w_done) begin
                wvalid = 1'b0;
            end
        end
        if (!(aw_done && w_done)) begin
            report_timeout("awready and wready");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            report_timeout("bvalid");
        end
        b_lat  = cycle_cnt - hs_at;
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int rready_delay,
                            output logic [31:0] data, output logic [1:0] resp,
                            output int hs_at, output int r_lat);
        int n;
        int i;
        logic [31:0] held;
        n       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!arready) begin
            report_timeout("arready");
        end
        hs_at = cycle_cnt;
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) begin
            report_timeout("rvalid");
        end
        r_lat = cycle_cnt - hs_at;
        held  = rdata;
        // rready low, response must stay put
        for (i = 0; i < rready_delay; i++) begin
            @(negedge clk);
            check_value("rvalid", rvalid, 1'b1);
            check_value("rdata", rdata, held);
        end
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // bits[0] is the start bit, bits[9] the stop bit
    task automatic uart_capture(output logic [9:0] bits);
        int n;
        int i;
        n = 0;
        while (uart_txd !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (uart_txd !== 1'b0) begin
            report_timeout("the uart start bit");
        end
        // half a bit period on to the bit centre
        repeat (`UART_CLKS_PER_BIT / 2 - 1) @(negedge clk);
        bits[0] = uart_txd;
        for (i = 1; i < 10; i++) begin
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            bits[i] = uart_txd;
        end
    endtask

    // capture ends mid stop bit, one more bit period reaches idle
    task automatic finish_stop_bit();
        repeat (`UART_CLKS_PER_BIT) @(negedge clk);
    endtask

    task test_uart_byte();
        int         rnd;
        logic [7:0] b;
        logic [9:0] frame;
        logic [1:0] resp;
        int         hs;
        int         lat;
        rnd = $random(seed);
        b   = rnd[7:0];
        fork
            uart_capture(frame);
            axi_write(`UART_BASE, {24'h0, b}, 0, 0, resp, hs, lat);
        join
        check_value("bresp", resp, okay);
        check_value("uart_txd start bit", frame[0], 1'b0);
        check_value("uart_txd data", frame[8:1], b);
        check_value("uart_txd stop bit", frame[9], 1'b1);
        finish_stop_bit();
        report_test("uart byte");
    endtask

    task test_busy_reject();
        int          rnd;
        logic [7:0]  b1;
        logic [9:0]  frame;
        logic [1:0]  resp;
        logic [31:0] data;
        int          hs;
        int          lat;
        rnd = $random(seed);
        b1  = rnd[7:0];
        fork
            uart_capture(frame);
            begin
                axi_write(`UART_BASE, {24'h0, b1}, 0, 0, resp, hs, lat);
                check_value("bresp", resp, okay);
                axi_read(`UART_BASE + 4, 0, data, resp, hs, lat);
                check_value("rdata status", data, 32'h1);
                check_value("rresp", resp, okay);
                // a different byte, dropped by the busy UART
                axi_write(`UART_BASE, {24'h0, ~b1}, 0, 0, resp, hs, lat);
                check_value("bresp", resp, slverr);
            end
        join
        check_value("uart_txd start bit", frame[0], 1'b0);
        check_value("uart_txd data", frame[8:1], b1);
        check_value("uart_txd stop bit", frame[9], 1'b1);
        finish_stop_bit();
        axi_read(`UART_BASE + 4, 0, data, resp, hs, lat);
        check_value("rdata status", data, 32'h0);
        report_test("busy and reject");
    endtask

    task test_timer();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] data;
        logic [1:0]  resp;
        int          w_hs;
        int          r_hs;
        int          lat;
        int          bound;
        hi = $random(seed);
        // top bits clear so the low word cannot wrap
        lo = $random(seed) & 32'h0fff_ffff;
        axi_write(`MTIME_BASE + 4, hi, 0, 0, resp, w_hs, lat);
        check_value("bresp", resp, okay);
        axi_write(`MTIME_BASE, lo, 0, 0, resp, w_hs, lat);
        check_value("bresp", resp, okay);
        axi_read(`MTIME_BASE, 0, data, resp, r_hs, lat);
        check_value("rresp", resp, okay);
        bound = r_hs - w_hs + 4;
        check_value("rdata mtime low within window", (data >= lo) && (data <= lo + bound), 1'b1);
        axi_read(`MTIME_BASE + 4, 0, data, resp, r_hs, lat);
        check_value("rdata mtime high", data, hi);
        check_value("rresp", resp, okay);
        report_test("timer load and count");
    endtask

    task test_unmapped();
        logic [31:0] data;
        logic [1:0]  resp;
        int          hs;
        int          lat;
        axi_write(32'h0000_1000, 32'hdead_beef, 0, 0, resp, hs, lat);
        check_value("bresp", resp, decerr);
        axi_read(32'h0000_1000, 0, data, resp, hs, lat);
        check_value("rresp", resp, decerr);
        check_value("rdata", data, 32'h0);
        report_test("unmapped address");
    endtask

    task test_order_backpressure();
        logic [31:0] data;
        logic [1:0]  resp;
        int          hs;
        int          lat;
        // W two cycles ahead of AW, status register ignores writes
        axi_write(`UART_BASE + 4, 32'h0, 2, 0, resp, hs, lat);
        check_value("bresp", resp, okay);
        check_value("bvalid latency", lat, 2);
        axi_write(`UART_BASE + 4, 32'h0, 0, 3, resp, hs, lat);
        check_value("bresp", resp, okay);
        check_value("bvalid latency", lat, 2);
        axi_read(`MTIME_BASE, 5, data, resp, hs, lat);
        check_value("rresp", resp, okay);
        check_value("rvalid latency", lat, 2);
        report_test("order and back-pressure");
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        awaddr  = 32'h0;
        awvalid = 1'b0;
        wdata   = 32'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = 32'h0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed    = 32'h88f;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("uart_txd", uart_txd, 1'b1);
        check_value("awready", awready, 1'b1);
        check_value("wready", wready, 1'b1);
        check_value("arready", arready, 1'b1);
        check_value("bvalid", bvalid, 1'b0);
        check_value("rvalid", rvalid, 1'b0);
        report_test("reset state");
        test_uart_byte();
        test_busy_reject();
        test_timer();
        test_unmapped();
        test_order_backpressure();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
src/periph_pkg.sv
src/axil_req_decode.sv
src/uart_tx.sv
src/mtime_counter.sv
src/axil_resp.sv
src/periph_top.sv
verif/periph_tb.sv

/* Bender.yml */
package:
  name: periph

dependencies: {}

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/periph_pkg.sv
      - src/axil_req_decode.sv
      - src/uart_tx.sv
      - src/mtime_counter.sv
      - src/axil_resp.sv
      - src/periph_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/periph_tb.sv
